//--- hdl/sqrt_pkg.sv
package sqrt_pkg;

    // ======================================================================
    // format widths
    // ======================================================================
    localparam int MANT_W     = 11;
    localparam int EXP_W      = 7;

    // one result bit per iteration
    localparam int ITER_COUNT = 11;

    // ======================================================================
    // special encodings
    // ======================================================================
    localparam logic signed [EXP_W-1:0] EXP_ZERO    = -7'sd15;
    localparam logic signed [EXP_W-1:0] EXP_SPECIAL = 7'sd16;
    localparam logic [MANT_W-1:0]       NAN_MANT    = 11'b100_0000_0000;

    // operand class after preparation
    typedef enum logic [1:0] {
        CLS_NUM,
        CLS_ZERO,
        CLS_NAN,
        CLS_PINF
    } op_class_t;

    // raw operand as it arrives at the top level
    typedef struct packed {
        logic                     sign;
        logic signed [EXP_W-1:0]  exp;
        logic [MANT_W-1:0]        mant;
        logic                     is_nan;
        logic                     is_pinf;
        logic                     is_ninf;
        logic                     is_num;
    } sqrt_raw_t;

    // finished result without a -Inf flag
    typedef struct packed {
        logic                     sign;
        logic signed [EXP_W-1:0]  exp;
        logic [MANT_W-1:0]        mant;
        logic                     is_nan;
        logic                     is_pinf;
    } sqrt_result_t;

endpackage

//--- hdl/sqrt_operand_if.sv
`timescale 1ns/1ps

interface sqrt_operand_if import sqrt_pkg::*; ();

    logic                    valid;
    logic                    ready;
    op_class_t               op_class;
    logic                    sign;
    // significand doubled when the exponent is odd
    logic [MANT_W:0]         work_mant;
    logic signed [EXP_W-1:0] half_exp;

    modport src (
        output valid, op_class, sign, work_mant, half_exp,
        input  ready
    );

    modport dst (
        input  valid, op_class, sign, work_mant, half_exp,
        output ready
    );

endinterface

//--- hdl/sqrt_stage_reg.sv
`timescale 1ns/1ps

module sqrt_stage_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic arst_n,

    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,

    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    logic full;
    T     data_q;

    // a new item may enter while the held one is leaving
    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;
        end
    end

    // payload register
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    // ======================================================================
    // checks
    // ======================================================================
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
    ) else $error("stage payload changed while stalled");

endmodule

//--- hdl/sqrt_operand_prep.sv
`timescale 1ns/1ps

module sqrt_operand_prep import sqrt_pkg::*; (
    input  logic      raw_valid,
    output logic      raw_ready,
    input  sqrt_raw_t raw,

    sqrt_operand_if.src op
);

    logic                    exp_odd;
    logic                    mant_zero;
    logic signed [EXP_W-1:0] adj_exp;
    op_class_t               cls;

    // handshake passes straight through
    assign op.valid  = raw_valid;
    assign raw_ready = op.ready;

    // ======================================================================
    // classification
    // ======================================================================
    assign mant_zero = (raw.mant == '0);

    // flags win over the zero code
    always_comb begin
        if (raw.is_nan || raw.is_ninf || !raw.is_num) begin
            cls = CLS_NAN;
        end else if (raw.is_pinf) begin
            cls = CLS_PINF;
        end else if ((raw.exp == EXP_ZERO) && mant_zero) begin
            cls = CLS_ZERO;
        end else begin
            cls = CLS_NUM;
        end
    end

    // ======================================================================
    // working significand and exponent
    // ======================================================================
    assign exp_odd = raw.exp[0];

    // an odd exponent doubles the significand and steps the exponent down to even
    assign op.work_mant = exp_odd ? {raw.mant, 1'b0} : {1'b0, raw.mant};
    assign adj_exp      = exp_odd ? (raw.exp - 7'sd1) : raw.exp;

    // adjusted exponent is even, so the shift is exact
    assign op.half_exp  = adj_exp >>> 1;

    assign op.op_class  = cls;
    assign op.sign      = raw.sign;

endmodule

//--- hdl/sqrt_digit_core.sv
`timescale 1ns/1ps

module sqrt_digit_core import sqrt_pkg::*; #(
    parameter int ITER_COUNT = sqrt_pkg::ITER_COUNT
) (
    input  logic         clk,
    input  logic         arst_n,

    sqrt_operand_if.dst  op,

    output logic         res_valid,
    input  logic         res_ready,
    output sqrt_result_t res
);

    // radicand is the working significand times 1024
    localparam int RAD_W = 2 * MANT_W;
    localparam int REM_W = MANT_W + 2;
    localparam int CNT_W = $clog2(ITER_COUNT + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ITER,
        ST_HOLD
    } state_t;

    state_t                  state;
    logic [CNT_W-1:0]        iter_cnt;

    logic [RAD_W-1:0]        radicand;
    logic [REM_W-1:0]        remainder;
    logic [MANT_W-1:0]       root;
    op_class_t               cls_q;
    logic                    sign_q;
    logic signed [EXP_W-1:0] exp_q;
    sqrt_result_t            res_q;

    logic                    op_fire;
    logic                    iter_done;
    logic [REM_W-1:0]        rem_shift;
    logic [REM_W-1:0]        trial;
    logic [REM_W-1:0]        rem_sub;
    logic                    take_one;
    sqrt_result_t            res_fmt;

    assign op.ready  = (state == ST_IDLE);
    assign op_fire   = op.valid && op.ready;
    assign iter_done = (iter_cnt == CNT_W'(ITER_COUNT));

    assign res_valid = (state == ST_HOLD);
    assign res       = res_q;

    // ======================================================================
    // restoring recurrence, one root bit per cycle
    // ======================================================================
    // bring down the next two radicand bits
    assign rem_shift = {remainder[REM_W-3:0], radicand[RAD_W-1 -: 2]};
    // trial value is root followed by 01
    assign trial     = {root, 2'b01};
    assign take_one  = (rem_shift >= trial);
    assign rem_sub   = rem_shift - trial;

    // specials skip the count, so they reach hold one cycle after capture
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            iter_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (op_fire) begin
                        state    <= ST_ITER;
                        iter_cnt <= (op.op_class == CLS_NUM) ? '0 : CNT_W'(ITER_COUNT);
                    end
                end
                ST_ITER: begin
                    if (iter_done) begin
                        state <= ST_HOLD;
                    end else begin
                        iter_cnt <= iter_cnt + CNT_W'(1);
                    end
                end
                ST_HOLD: begin
                    if (res_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (op_fire) begin
            radicand  <= {op.work_mant, {(MANT_W - 1){1'b0}}};
            remainder <= '0;
            root      <= '0;
            cls_q     <= op.op_class;
            sign_q    <= op.sign;
            exp_q     <= op.half_exp;
        end else if ((state == ST_ITER) && !iter_done) begin
            radicand  <= radicand << 2;
            remainder <= take_one ? rem_sub : rem_shift;
            root      <= {root[MANT_W-2:0], take_one};
        end

        if ((state == ST_ITER) && iter_done) begin
            res_q <= res_fmt;
        end
    end

    // ======================================================================
    // result formatting
    // ======================================================================
    always_comb begin
        res_fmt = '0;
        case (cls_q)
            CLS_NUM: begin
                res_fmt.exp  = exp_q;
                res_fmt.mant = root;
            end
            CLS_ZERO: begin
                // zero keeps its sign
                res_fmt.sign = sign_q;
                res_fmt.exp  = EXP_ZERO;
            end
            CLS_NAN: begin
                res_fmt.sign   = 1'b1;
                res_fmt.exp    = EXP_SPECIAL;
                res_fmt.mant   = NAN_MANT;
                res_fmt.is_nan = 1'b1;
            end
            default: begin
                res_fmt.exp     = EXP_SPECIAL;
                res_fmt.is_pinf = 1'b1;
            end
        endcase
    end

    // ======================================================================
    // checks
    // ======================================================================
    a_cnt_bound: assert property (
        @(posedge clk) disable iff (!arst_n)
        iter_cnt <= CNT_W'(ITER_COUNT)
    ) else $error("iteration counter past limit");

    a_no_accept_busy: assert property (
        @(posedge clk) disable iff (!arst_n)
        op_fire |=> !op.ready
    ) else $error("operand accepted while core busy");

endmodule

//--- hdl/sqrt_unit.sv
`timescale 1ns/1ps

module sqrt_unit import sqrt_pkg::*; #(
    parameter int ITER_COUNT = sqrt_pkg::ITER_COUNT
) (
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic                    sign_in,
    input  logic signed [EXP_W-1:0] exp_in,
    input  logic [MANT_W-1:0]       mant_in,
    input  logic                    is_nan_in,
    input  logic                    is_pinf_in,
    input  logic                    is_ninf_in,
    input  logic                    is_num,

    output logic                    out_valid,
    input  logic                    out_ready,
    output logic                    sign_out,
    output logic signed [EXP_W-1:0] exp_out,
    output logic [MANT_W-1:0]       mant_out,
    output logic                    is_nan_out,
    output logic                    is_pinf_out
);

    sqrt_raw_t    raw_in;
    sqrt_raw_t    raw_q;
    logic         raw_valid;
    logic         raw_ready;

    logic         res_valid;
    logic         res_ready;
    sqrt_result_t res;
    sqrt_result_t res_out;

    sqrt_operand_if op_if ();

    assign raw_in = '{
        sign:    sign_in,
        exp:     exp_in,
        mant:    mant_in,
        is_nan:  is_nan_in,
        is_pinf: is_pinf_in,
        is_ninf: is_ninf_in,
        is_num:  is_num
    };

    // ======================================================================
    // input stage, preparation, recurrence, output stage
    // ======================================================================
    sqrt_stage_reg #(.T(sqrt_raw_t)) i_in_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (raw_in),
        .out_valid (raw_valid),
        .out_ready (raw_ready),
        .out_data  (raw_q)
    );

    sqrt_operand_prep i_prep (
        .raw_valid (raw_valid),
        .raw_ready (raw_ready),
        .raw       (raw_q),
        .op        (op_if.src)
    );

    sqrt_digit_core #(.ITER_COUNT(ITER_COUNT)) i_core (
        .clk       (clk),
        .arst_n    (arst_n),
        .op        (op_if.dst),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res       (res)
    );

    sqrt_stage_reg #(.T(sqrt_result_t)) i_out_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (res_valid),
        .in_ready  (res_ready),
        .in_data   (res),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (res_out)
    );

    assign sign_out    = res_out.sign;
    assign exp_out     = res_out.exp;
    assign mant_out    = res_out.mant;
    assign is_nan_out  = res_out.is_nan;
    assign is_pinf_out = res_out.is_pinf;

endmodule

//--- sim/tb_sqrt_unit.sv
`timescale 1ns/1ps

module tb_sqrt_unit import sqrt_pkg::*; ();

    localparam string PATTERN_FILE = "sim/sqrt_patterns.txt";

    // one line of the pattern file
    typedef struct packed {
        int sign;
        int exp;
        int mant;
        int nan;
        int pinf;
        int ninf;
        int num;
        int e_sign;
        int e_exp;
        int e_mant;
        int e_nan;
        int e_pinf;
    } pattern_t;

    logic                    clk;
    logic                    arst_n;
    logic                    in_valid;
    logic                    in_ready;
    logic                    sign_in;
    logic signed [EXP_W-1:0] exp_in;
    logic [MANT_W-1:0]       mant_in;
    logic                    is_nan_in;
    logic                    is_pinf_in;
    logic                    is_ninf_in;
    logic                    is_num;
    logic                    out_valid;
    logic                    out_ready;
    logic                    sign_out;
    logic signed [EXP_W-1:0] exp_out;
    logic [MANT_W-1:0]       mant_out;
    logic                    is_nan_out;
    logic                    is_pinf_out;

    pattern_t    patterns[$];
    // indices of sent operands in the order they entered the DUT
    int          sent_idx[$];
    int          error_count = 0;
    int          rx_count = 0;
    bit          patterns_loaded = 1'b0;

    sqrt_unit i_sqrt_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .sign_in     (sign_in),
        .exp_in      (exp_in),
        .mant_in     (mant_in),
        .is_nan_in   (is_nan_in),
        .is_pinf_in  (is_pinf_in),
        .is_ninf_in  (is_ninf_in),
        .is_num      (is_num),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .sign_out    (sign_out),
        .exp_out     (exp_out),
        .mant_out    (mant_out),
        .is_nan_out  (is_nan_out),
        .is_pinf_out (is_pinf_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ======================================================================
    // helpers
    // ======================================================================
    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            error_count++;
            $display("Error at %0t: %s expected %0d, got %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic load_patterns();
        int       fd;
        int       got;
        int       f[12];
        string    line;
        pattern_t p;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            error_count++;
            $display("cannot open pattern file %s", PATTERN_FILE);
            return;
        end
        while ($fgets(line, fd) != 0) begin
            // comment and blank lines
            if (line.len() < 2 || line.getc(0) == "#") continue;
            got = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d",
                          f[0], f[1], f[2], f[3], f[4], f[5],
                          f[6], f[7], f[8], f[9], f[10], f[11]);
            if (got != 12) begin
                error_count++;
                $display("pattern line has %0d fields instead of 12: %s", got, line);
                continue;
            end
            p.sign   = f[0];
            p.exp    = f[1];
            p.mant   = f[2];
            p.nan    = f[3];
            p.pinf   = f[4];
            p.ninf   = f[5];
            p.num    = f[6];
            p.e_sign = f[7];
            p.e_exp  = f[8];
            p.e_mant = f[9];
            p.e_nan  = f[10];
            p.e_pinf = f[11];
            patterns.push_back(p);
        end
        $fclose(fd);
    endtask

    task automatic apply_reset();
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        #1;
        check_value("out_valid", 0, int'(out_valid));
        check_value("in_ready", 1, int'(in_ready));
    endtask

    task automatic apply_operand(input pattern_t p);
        in_valid   = 1'b1;
        sign_in    = p.sign[0];
        exp_in     = EXP_W'(p.exp);
        mant_in    = MANT_W'(p.mant);
        is_nan_in  = p.nan[0];
        is_pinf_in = p.pinf[0];
        is_ninf_in = p.ninf[0];
        is_num     = p.num[0];
    endtask

    task automatic compare_result(input pattern_t p);
        check_value("sign_out", p.e_sign, int'(sign_out));
        check_value("exp_out", p.e_exp, int'(exp_out));
        check_value("mant_out", p.e_mant, int'(mant_out));
        check_value("is_nan_out", p.e_nan, int'(is_nan_out));
        check_value("is_pinf_out", p.e_pinf, int'(is_pinf_out));
    endtask

    // ======================================================================
    // driver and monitor
    // ======================================================================
    task automatic drive_operands();
        int gap;
        for (int i = 0; i < patterns.size(); i++) begin
            // mostly back-to-back with an idle gap now and then
            gap = ($urandom % 3 == 0) ? int'($urandom % 4) : 0;
            repeat (gap) begin
                @(negedge clk);
                in_valid = 1'b0;
            end
            @(negedge clk);
            apply_operand(patterns[i]);
            #1;
            while (!in_ready) begin
                @(negedge clk);
                #1;
            end
            // transfer happens on the coming rising edge
            sent_idx.push_back(i);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic collect_results();
        int k;
        while (rx_count < patterns.size()) begin
            @(negedge clk);
            // ready about half the time so the stages fill up
            out_ready = ($urandom % 2) == 0;
            #1;
            if (out_valid && out_ready) begin
                assert (sent_idx.size() != 0) else begin
                    error_count++;
                    $display("result at %0t came with no operand outstanding", $time);
                end
                if (sent_idx.size() != 0) begin
                    k = sent_idx.pop_front();
                    compare_result(patterns[k]);
                end
                rx_count++;
            end
        end
    endtask

    task automatic check_drained();
        @(negedge clk);
        out_ready = 1'b1;
        repeat (20) begin
            @(negedge clk);
            #1;
            assert (!out_valid) else begin
                error_count++;
                $display("extra result at %0t after the last pattern", $time);
            end
        end
        check_value("in_ready", 1, int'(in_ready));
    endtask

    // ======================================================================
    // main sequence and watchdog
    // ======================================================================
    initial begin : main_seq
        void'($urandom(32'h3553));
        $timeformat(-9, 0, " ns", 0);
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        sign_in    = 1'b0;
        exp_in     = '0;
        mant_in    = '0;
        is_nan_in  = 1'b0;
        is_pinf_in = 1'b0;
        is_ninf_in = 1'b0;
        is_num     = 1'b0;
        out_ready  = 1'b0;

        load_patterns();
        if (patterns.size() == 0) begin
            error_count++;
            $display("no usable patterns in %s", PATTERN_FILE);
        end else begin
            patterns_loaded = 1'b1;
            apply_reset();
            fork
                drive_operands();
                collect_results();
            join
            check_drained();
        end

        $display("results checked: %0d of %0d, errors: %0d",
                 rx_count, patterns.size(), error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (patterns_loaded);
        repeat (patterns.size() * 40 + 100) @(posedge clk);
        $display("timeout: only %0d of %0d results arrived in time",
                 rx_count, patterns.size());
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- sources.f
hdl/sqrt_pkg.sv
hdl/sqrt_operand_if.sv
hdl/sqrt_stage_reg.sv
hdl/sqrt_operand_prep.sv
hdl/sqrt_digit_core.sv
hdl/sqrt_unit.sv
sim/tb_sqrt_unit.sv

//--- run_sim.sh
#!/bin/sh
# build and run the square-root testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_sqrt_unit \
    --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints the fail message on a line of its own
if grep -qx "CHECKS FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- sim/sqrt_patterns.txt
# operand: sign exp mant nan pinf ninf num, then expected: sign exp mant nan pinf
# exponents are signed decimal, significands decimal
0 0 1024 0 0 0 1 0 0 1024 0 0
0 2 1089 0 0 0 1 0 1 1056 0 0
1 -2 1156 0 0 0 1 0 -1 1088 0 0
0 14 1225 0 0 0 1 0 7 1120 0 0
0 -14 1296 0 0 0 1 0 -7 1152 0 0
0 62 1369 0 0 0 1 0 31 1184 0 0
1 -64 1444 0 0 0 1 0 -32 1216 0 0
0 6 1521 0 0 0 1 0 3 1248 0 0
0 -15 0 0 0 0 1 0 -15 0 0 0
0 16 1024 1 0 0 0 1 16 1024 1 0
0 4 1600 0 0 0 1 0 2 1280 0 0
0 16 0 0 1 0 1 0 16 0 0 1
1 16 0 0 0 1 1 1 16 1024 1 0
0 -8 1681 0 0 0 1 0 -4 1312 0 0
1 -15 0 0 0 0 1 1 -15 0 0 0
0 10 1764 0 0 0 1 0 5 1344 0 0
0 8 1849 0 0 0 1 0 4 1376 0 0
1 12 1936 0 0 0 1 0 6 1408 0 0
0 20 2025 0 0 0 1 0 10 1440 0 0
0 -10 2047 0 0 0 1 0 -5 1447 0 0
0 -4 1500 0 0 0 1 0 -2 1239 0 0
0 0 1100 0 0 0 1 0 0 1061 0 0
0 1 1024 0 0 0 1 0 0 1448 0 0
0 3 1152 0 0 0 1 0 1 1536 0 0
1 -1 1250 0 0 0 1 0 -1 1600 0 0
0 -3 1352 0 0 0 1 0 -2 1664 0 0
0 63 1458 0 0 0 1 0 31 1728 0 0
0 -63 1568 0 0 0 1 0 -32 1792 0 0
0 5 1682 0 0 0 1 0 2 1856 0 0
0 -15 1800 0 0 0 1 0 -8 1920 0 0
0 7 1922 0 0 0 1 0 3 1984 0 0
1 -5 2047 0 0 0 1 0 -3 2047 0 0
0 9 1300 0 0 0 1 0 4 1631 0 0
0 3 1500 0 0 0 0 1 16 1024 1 0
0 -15 0 0 0 0 0 1 16 1024 1 0
1 16 0 0 1 0 1 0 16 0 0 1
0 16 1024 1 1 0 1 1 16 1024 1 0
0 4 0 0 0 0 1 0 2 0 0 0
